/* run_sim.sh */
#!/usr/bin/env bash
# Build the soc_harness testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_harness -f soc_harness.f --Mdir "$BUILD_DIR" -o sim_soc_harness
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_soc_harness" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "*** PASSED ***" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

/* soc_harness.f */
verilog/harness_pkg.sv
verilog/reset_sync.sv
verilog/bus_demux.sv
verilog/boot_rom.sv
verilog/sram_bank.sv
verilog/clint_timer.sv
verilog/debug_holdoff.sv
verilog/soc_harness.sv
verification/soc_harness_assertions.sv
verification/tb_soc_harness.sv

/* verification/soc_harness_assertions.sv */
/*
  Concurrent assertions on the harness top level
  Response timing, grant, error strobe and debug hold-off
*/
`timescale 1ns/1ps

module soc_harness_assertions import harness_pkg::*; (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       periph_rst_ni,
  input bus_req_t                   bus_req_i,
  input bus_rsp_t                   bus_rsp_i,
  input logic                       dbg_req_gated_i,
  input logic [HoldoffCntWidth-1:0] holdoff_cnt_i
);

  // Response comes exactly one cycle after a transfer
  assert property (@(posedge clk_i) disable iff (!periph_rst_ni)
    (bus_req_i.req && bus_rsp_i.gnt) |=> bus_rsp_i.rvalid)
    else $error("rvalid missing one cycle after a transfer");

  assert property (@(posedge clk_i) disable iff (!periph_rst_ni)
    bus_rsp_i.rvalid |-> $past(bus_req_i.req && bus_rsp_i.gnt))
    else $error("rvalid without a transfer in the previous cycle");

  assert property (@(posedge clk_i) bus_rsp_i.gnt |-> bus_req_i.req)
    else $error("gnt high without req");

  assert property (@(posedge clk_i) bus_rsp_i.err |-> bus_rsp_i.rvalid)
    else $error("err high without rvalid");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (holdoff_cnt_i != '0) |-> !dbg_req_gated_i)
    else $error("debug request passed during hold-off");

endmodule

bind soc_harness soc_harness_assertions u_assertions (
  .clk_i           ( clk_i                   ),
  .rst_ni          ( rst_ni                  ),
  .periph_rst_ni   ( periph_rst_n            ),
  .bus_req_i       ( bus_req_i               ),
  .bus_rsp_i       ( bus_rsp_o               ),
  .dbg_req_gated_i ( debug_req_o             ),
  .holdoff_cnt_i   ( u_holdoff.holdoff_cnt_q )
);

/* verification/tb_soc_harness.sv */
/*
  Testbench for the SoC harness
  Clock, reset, bus access and compare tasks, watchdog
  Directed tests for debug hold-off, SRAM, boot ROM,
  unmapped addresses, CLINT timer and non-debug-mode reset
*/
`timescale 1ns/1ps

module tb_soc_harness import harness_pkg::*; ();

  localparam int ClkPeriod      = 40;
  localparam int ResetCycles    = 5;
  localparam int BusTestCycles  = 200;
  localparam int WatchdogCycles = 2 * (ResetCycles + DebugHoldoffCycles + BusTestCycles);
  localparam int GrantTimeout   = 20;
  localparam int RtcPulses      = 5;

  logic     clk;
  logic     rst_n;
  logic     rtc;
  logic     ndmreset;
  logic     debug_req;
  logic     debug_req_out;
  logic     timer_irq;
  logic     ipi;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;

  int errors;
  int checks;
  int seed;

  soc_harness u_dut (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .rtc_i       ( rtc           ),
    .ndmreset_i  ( ndmreset      ),
    .debug_req_i ( debug_req     ),
    .bus_req_i   ( bus_req       ),
    .bus_rsp_o   ( bus_rsp       ),
    .timer_irq_o ( timer_irq     ),
    .ipi_o       ( ipi           ),
    .debug_req_o ( debug_req_out )
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic data_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // All ones in every enabled byte lane
  function automatic data_t byte_mask(strb_t be);
    data_t mask;
    mask = '0;
    for (int i = 0; i < StrbWidth; i++) begin
      if (be[i]) begin
        mask[i*8 +: 8] = 8'hFF;
      end
    end
    return mask;
  endfunction

  function automatic bus_req_t make_req(logic we, addr_t addr, strb_t be, data_t wdata);
    bus_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.be    = be;
    r.wdata = wdata;
    return r;
  endfunction

  // ------------------------------------------------------------
  // One transfer with the response sampled on the falling edge
  // ------------------------------------------------------------
  task automatic bus_access(input logic we, input addr_t addr, input strb_t be,
                            input data_t wdata, output data_t rdata, output logic err);
    int waited;
    rdata  = '0;
    err    = 1'b0;
    waited = 0;
    @(posedge clk);
    bus_req <= make_req(we, addr, be, wdata);
    @(negedge clk);
    while (!bus_rsp.gnt && waited < GrantTimeout) begin
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    bus_req <= '0;
    if (waited >= GrantTimeout) begin
      errors++;
      $display("No grant for the request to address %h", addr);
      return;
    end
    @(negedge clk);
    if (!bus_rsp.rvalid) begin
      errors++;
      $display("No response in the cycle after the transfer to address %h", addr);
      return;
    end
    rdata = bus_rsp.rdata;
    err   = bus_rsp.err;
  endtask

  task automatic rtc_pulse();
    @(posedge clk);
    rtc <= 1'b1;
    repeat (4) @(posedge clk);
    rtc <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_debug_holdoff();
    int early;
    early = 0;
    // Power-on reset released with the request already pending
    rst_n     <= 1'b1;
    debug_req <= 1'b1;
    for (int i = 1; i < DebugHoldoffCycles; i++) begin
      @(posedge clk);
      @(negedge clk);
      if (debug_req_out) begin
        early++;
      end
    end
    check_value("test_debug_holdoff early", '0, data_t'(early));
    @(posedge clk);
    @(negedge clk);
    check_value("test_debug_holdoff released", 64'd1, data_t'(debug_req_out));
    @(posedge clk);
    debug_req <= 1'b0;
    @(negedge clk);
    check_value("test_debug_holdoff dropped", '0, data_t'(debug_req_out));
  endtask

  task automatic test_sram();
    int unsigned idx [4] = '{0, 5, 100, 1023};
    data_t       shadow [4];
    data_t       wdata;
    data_t       rdata;
    strb_t       be;
    logic        err;
    for (int k = 0; k < 4; k++) begin
      shadow[k] = rand_word();
      bus_access(1'b1, SramBase + addr_t'(idx[k] * 8), '1, shadow[k], rdata, err);
    end
    for (int k = 0; k < 4; k++) begin
      be    = (k == 0) ? 8'h01 : strb_t'($random(seed));
      wdata = rand_word();
      bus_access(1'b1, SramBase + addr_t'(idx[k] * 8), be, wdata, rdata, err);
      check_value("test_sram write err", '0, data_t'(err));
      shadow[k] = (shadow[k] & ~byte_mask(be)) | (wdata & byte_mask(be));
    end
    for (int k = 0; k < 4; k++) begin
      bus_access(1'b0, SramBase + addr_t'(idx[k] * 8), '1, '0, rdata, err);
      check_value("test_sram readback", shadow[k], rdata);
    end
  endtask

  task automatic test_rom();
    int unsigned idx [4] = '{0, 1, 77, 511};
    data_t       rdata;
    logic        err;
    for (int k = 0; k < 4; k++) begin
      bus_access(1'b0, RomBase + addr_t'(idx[k] * 8), '1, '0, rdata, err);
      check_value("test_rom read", {32'hB007_0000, idx[k]}, rdata);
    end
    bus_access(1'b1, RomBase + addr_t'(77 * 8), '1, rand_word(), rdata, err);
    check_value("test_rom write err", '0, data_t'(err));
    bus_access(1'b0, RomBase + addr_t'(77 * 8), '1, '0, rdata, err);
    check_value("test_rom after write", {32'hB007_0000, 32'd77}, rdata);
  endtask

  task automatic test_unmapped();
    addr_t    bad [4] = '{32'h0000_0100, 32'h0001_1000, 32'h4000_0000, 32'h8000_2000};
    bus_req_t reqs [5];
    data_t    exp_rdata [5];
    logic     exp_err [5];
    data_t    rdata;
    data_t    d;
    logic     err;
    for (int k = 0; k < 4; k++) begin
      for (int w = 0; w < 2; w++) begin
        bus_access(w[0], bad[k], '1, rand_word(), rdata, err);
        check_value("test_unmapped err", 64'd1, data_t'(err));
        check_value("test_unmapped rdata", '0, rdata);
      end
    end
    // Back-to-back transfers to mixed regions
    d = rand_word();
    reqs[0] = make_req(1'b1, SramBase + 32'h40, '1, d);
    reqs[1] = make_req(1'b0, RomBase + 32'h18, '1, '0);
    reqs[2] = make_req(1'b0, 32'h4000_0000, '1, '0);
    reqs[3] = make_req(1'b0, SramBase + 32'h40, '1, '0);
    reqs[4] = make_req(1'b0, ClintBase + MsipOffset, '1, '0);
    exp_rdata = '{'0, {32'hB007_0000, 32'd3}, '0, d, '0};
    exp_err   = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    @(posedge clk);
    bus_req <= reqs[0];
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      bus_req <= (i < 4) ? reqs[i+1] : '0;
      @(negedge clk);
      check_value("test_unmapped burst gnt", data_t'(i < 4), data_t'(bus_rsp.gnt));
      check_value("test_unmapped burst rvalid", 64'd1, data_t'(bus_rsp.rvalid));
      check_value("test_unmapped burst err", data_t'(exp_err[i]), data_t'(bus_rsp.err));
      check_value("test_unmapped burst rdata", exp_rdata[i], bus_rsp.rdata);
    end
    @(negedge clk);
    check_value("test_unmapped burst end", '0, data_t'(bus_rsp.rvalid));
  endtask

  task automatic test_clint();
    data_t rdata;
    logic  err;
    bus_access(1'b1, ClintBase + MsipOffset, '1, 64'd1, rdata, err);
    check_value("test_clint ipi set", 64'd1, data_t'(ipi));
    bus_access(1'b1, ClintBase + MsipOffset, '1, '0, rdata, err);
    check_value("test_clint ipi clear", '0, data_t'(ipi));
    repeat (RtcPulses) rtc_pulse();
    bus_access(1'b0, ClintBase + MtimeOffset, '1, '0, rdata, err);
    check_value("test_clint mtime", data_t'(RtcPulses), rdata);
    bus_access(1'b1, ClintBase + MtimecmpOffset, '1, data_t'(RtcPulses + 2), rdata, err);
    check_value("test_clint irq low", '0, data_t'(timer_irq));
    repeat (2) rtc_pulse();
    @(negedge clk);
    check_value("test_clint irq high", 64'd1, data_t'(timer_irq));
  endtask

  task automatic test_ndmreset();
    data_t rdata;
    data_t d;
    logic  err;
    d = rand_word();
    bus_access(1'b1, SramBase + 32'h100, '1, d, rdata, err);
    bus_access(1'b1, ClintBase + MtimecmpOffset, '1, 64'h1234, rdata, err);
    @(posedge clk);
    ndmreset <= 1'b1;
    repeat (2) @(posedge clk);
    ndmreset <= 1'b0;
    bus_access(1'b0, ClintBase + MtimeOffset, '1, '0, rdata, err);
    check_value("test_ndmreset mtime", '0, rdata);
    bus_access(1'b0, ClintBase + MtimecmpOffset, '1, '0, rdata, err);
    check_value("test_ndmreset mtimecmp", '1, rdata);
    bus_access(1'b0, SramBase + 32'h100, '1, '0, rdata, err);
    check_value("test_ndmreset sram kept", d, rdata);
  endtask

  initial begin
    seed      = 97597;
    errors    = 0;
    checks    = 0;
    rst_n     = 1'b0;
    rtc       = 1'b0;
    ndmreset  = 1'b0;
    debug_req = 1'b0;
    bus_req   = '0;
    repeat (ResetCycles) @(posedge clk);
    test_debug_holdoff();
    test_sram();
    test_rom();
    test_unmapped();
    test_clint();
    test_ndmreset();
    repeat (2) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Twice the expected run length
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WatchdogCycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* verilog/boot_rom.sv */
/*
  Boot ROM
  Word i holds the signature in the upper half and i in the lower half,
  read data registered one cycle after the request, writes ignored
*/
`timescale 1ns/1ps

module boot_rom import harness_pkg::*; (
  input  logic     clk_i,
  input  bus_req_t req_i,
  output data_t    rdata_o
);

  logic [RomIdxBits-1:0] word_idx;
  data_t                 rom_word;
  data_t                 rdata_q;

  assign word_idx = req_i.addr[WordOffsetBits +: RomIdxBits];

  // Content rule
  always_comb begin
    rom_word        = '0;
    rom_word[63:32] = RomSignature;
    rom_word[31:0]  = 32'(word_idx);
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_q <= rom_word;
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* verilog/bus_demux.sv */
/*
  Bus address decoder
  Steers the master request to boot ROM, SRAM or CLINT,
  tracks the slave of each transfer for one cycle and forms
  rvalid, err and read data, with an error for unmapped addresses
*/
`timescale 1ns/1ps

module bus_demux import harness_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output bus_req_t rom_req_o,
  output bus_req_t sram_req_o,
  output bus_req_t clint_req_o,
  input  data_t    rom_rdata_i,
  input  data_t    sram_rdata_i,
  input  data_t    clint_rdata_i
);

  slave_sel_e sel;
  slave_sel_e sel_q;
  logic       gnt;
  logic       valid_q;
  logic       we_q;
  data_t      rdata;

  function automatic logic in_region(addr_t addr, addr_t base, addr_t length);
    return (addr >= base) && ((addr - base) < length);
  endfunction

  // ------------------------------------------------------------
  // Decode and steering
  // ------------------------------------------------------------
  always_comb begin
    if (in_region(bus_req_i.addr, RomBase, RomLength)) begin
      sel = SelRom;
    end else if (in_region(bus_req_i.addr, SramBase, SramLength)) begin
      sel = SelSram;
    end else if (in_region(bus_req_i.addr, ClintBase, ClintLength)) begin
      sel = SelClint;
    end else begin
      sel = SelNone;
    end
  end

  // Every slave accepts at once so only reset holds off the grant
  assign gnt = bus_req_i.req & rst_ni;

  always_comb begin
    rom_req_o       = bus_req_i;
    sram_req_o      = bus_req_i;
    clint_req_o     = bus_req_i;
    rom_req_o.req   = gnt && (sel == SelRom);
    sram_req_o.req  = gnt && (sel == SelSram);
    clint_req_o.req = gnt && (sel == SelClint);
  end

  // ------------------------------------------------------------
  // Response tracking
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      sel_q   <= SelNone;
      we_q    <= 1'b0;
    end else begin
      valid_q <= gnt;
      if (gnt) begin
        sel_q <= sel;
        we_q  <= bus_req_i.we;
      end
    end
  end

  // Writes and errors return zero data
  always_comb begin
    rdata = '0;
    if (valid_q && !we_q) begin
      case (sel_q)
        SelRom:   rdata = rom_rdata_i;
        SelSram:  rdata = sram_rdata_i;
        SelClint: rdata = clint_rdata_i;
        default:  rdata = '0;
      endcase
    end
  end

  assign bus_rsp_o.gnt    = gnt;
  assign bus_rsp_o.rvalid = valid_q;
  assign bus_rsp_o.err    = valid_q && (sel_q == SelNone);
  assign bus_rsp_o.rdata  = rdata;

endmodule

/* verilog/clint_timer.sv */
/*
  CLINT-style timer
  rtc_i synchronizer and rising edge detect driving mtime
  mtime, mtimecmp and msip registers with byte-enable writes
  Registered reads, timer interrupt and software interrupt
*/
`timescale 1ns/1ps

module clint_timer import harness_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rtc_i,
  input  bus_req_t req_i,
  output data_t    rdata_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  logic [1:0] rtc_sync_q;
  logic       rtc_prev_q;
  logic       rtc_rise;

  addr_t offset;
  addr_t word_offset;
  logic  sel_msip;
  logic  sel_mtimecmp;
  logic  sel_mtime;

  data_t mtime_q;
  data_t mtimecmp_q;
  data_t msip_q;
  data_t rdata_q;

  // ------------------------------------------------------------
  // RTC edge detect
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= 2'b00;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  // ------------------------------------------------------------
  // Register decode
  // ------------------------------------------------------------
  assign offset       = req_i.addr - ClintBase;
  assign word_offset  = {offset[AddrWidth-1:WordOffsetBits], {WordOffsetBits{1'b0}}};
  assign sel_msip     = (word_offset == MsipOffset);
  assign sel_mtimecmp = (word_offset == MtimecmpOffset);
  assign sel_mtime    = (word_offset == MtimeOffset);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= '0;
    end else begin
      // Bus write wins over the tick
      if (req_i.req && req_i.we && sel_mtime) begin
        mtime_q <= merge_bytes(mtime_q, req_i.wdata, req_i.be);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (req_i.req && req_i.we && sel_mtimecmp) begin
        mtimecmp_q <= merge_bytes(mtimecmp_q, req_i.wdata, req_i.be);
      end
      if (req_i.req && req_i.we && sel_msip) begin
        msip_q <= merge_bytes(msip_q, req_i.wdata, req_i.be);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      if (sel_mtime) begin
        rdata_q <= mtime_q;
      end else if (sel_mtimecmp) begin
        rdata_q <= mtimecmp_q;
      end else if (sel_msip) begin
        rdata_q <= msip_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q[0];

endmodule

/* verilog/debug_holdoff.sv */
/*
  Debug request hold-off
  Blocks the debug request for DebugHoldoffCycles clocks
  after power-on reset, then passes it through
*/
`timescale 1ns/1ps

module debug_holdoff import harness_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [HoldoffCntWidth-1:0] holdoff_cnt_q;

  // Counts down once and parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      holdoff_cnt_q <= HoldoffCntWidth'(DebugHoldoffCycles);
    end else if (holdoff_cnt_q != '0) begin
      holdoff_cnt_q <= holdoff_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (holdoff_cnt_q == '0) & debug_req_i;

endmodule

/* verilog/harness_pkg.sv */
/*
  Shared definitions for the SoC harness
  Bus and memory widths, address map and CLINT register offsets
  Boot ROM content signature and debug hold-off count
  Bus request and response structs, slave select enum
  Byte-enable merge helper
*/
package harness_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 64;
  localparam int unsigned StrbWidth      = DataWidth / 8;
  localparam int unsigned WordOffsetBits = 3;

  localparam int unsigned RomWords    = 512;
  localparam int unsigned SramWords   = 1024;
  localparam int unsigned RomIdxBits  = $clog2(RomWords);
  localparam int unsigned SramIdxBits = $clog2(SramWords);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // ------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------
  localparam addr_t RomBase     = 32'h0001_0000;
  localparam addr_t RomLength   = 32'h0000_1000;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h000C_0000;
  localparam addr_t SramBase    = 32'h8000_0000;
  localparam addr_t SramLength  = 32'h0000_2000;

  // Offsets of the 64-bit CLINT registers
  localparam addr_t MsipOffset     = 32'h0000_0000;
  localparam addr_t MtimecmpOffset = 32'h0000_4000;
  localparam addr_t MtimeOffset    = 32'h0000_BFF8;

  // Upper half of every ROM word
  localparam logic [31:0] RomSignature = 32'hB007_0000;

  localparam int unsigned DebugHoldoffCycles = 500;
  localparam int unsigned HoldoffCntWidth    = $clog2(DebugHoldoffCycles + 1);

  // ------------------------------------------------------------
  // Bus types
  // ------------------------------------------------------------
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    strb_t be;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    SelNone,
    SelRom,
    SelSram,
    SelClint
  } slave_sel_e;

  // Replace the enabled bytes of a word
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t be);
    data_t result;
    result = old_word;
    for (int i = 0; i < StrbWidth; i++) begin
      if (be[i]) begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

endpackage

/* verilog/reset_sync.sv */
/*
  Peripheral reset generator
  Power-on reset combined with the non-debug-mode reset request,
  asserted asynchronously and released through a two-flop chain
*/
`timescale 1ns/1ps

module reset_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic periph_rst_no
);

  logic       comb_rst_n;
  logic [1:0] sync_q;

  assign comb_rst_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge comb_rst_n) begin
    if (!comb_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign periph_rst_no = sync_q[1];

endmodule

/* verilog/soc_harness.sv */
/*
  SoC harness top level
  Peripheral reset generator, bus decoder, boot ROM, SRAM,
  CLINT timer and debug request hold-off
*/
`timescale 1ns/1ps

module soc_harness import harness_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rtc_i,
  input  logic     ndmreset_i,
  input  logic     debug_req_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output logic     timer_irq_o,
  output logic     ipi_o,
  output logic     debug_req_o
);

  logic     periph_rst_n;
  bus_req_t rom_req;
  bus_req_t sram_req;
  bus_req_t clint_req;
  data_t    rom_rdata;
  data_t    sram_rdata;
  data_t    clint_rdata;

  reset_sync u_reset_sync (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .ndmreset_i    ( ndmreset_i   ),
    .periph_rst_no ( periph_rst_n )
  );

  // ------------------------------------------------------------
  // Bus and slaves
  // ------------------------------------------------------------
  bus_demux u_demux (
    .clk_i         ( clk_i        ),
    .rst_ni        ( periph_rst_n ),
    .bus_req_i     ( bus_req_i    ),
    .bus_rsp_o     ( bus_rsp_o    ),
    .rom_req_o     ( rom_req      ),
    .sram_req_o    ( sram_req     ),
    .clint_req_o   ( clint_req    ),
    .rom_rdata_i   ( rom_rdata    ),
    .sram_rdata_i  ( sram_rdata   ),
    .clint_rdata_i ( clint_rdata  )
  );

  boot_rom u_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .rdata_o ( rom_rdata )
  );

  sram_bank u_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .rdata_o ( sram_rdata )
  );

  clint_timer u_clint (
    .clk_i       ( clk_i        ),
    .rst_ni      ( periph_rst_n ),
    .rtc_i       ( rtc_i        ),
    .req_i       ( clint_req    ),
    .rdata_o     ( clint_rdata  ),
    .timer_irq_o ( timer_irq_o  ),
    .ipi_o       ( ipi_o        )
  );

  // Runs on power-on reset only
  debug_holdoff u_holdoff (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

/* verilog/sram_bank.sv */
/*
  Single-port SRAM
  SramWords words of DataWidth bits, byte-enable writes,
  read data registered one cycle after the request
*/
`timescale 1ns/1ps

module sram_bank import harness_pkg::*; (
  input  logic     clk_i,
  input  bus_req_t req_i,
  output data_t    rdata_o
);

  data_t                  mem [SramWords];
  logic [SramIdxBits-1:0] word_idx;
  data_t                  rdata_q;

  assign word_idx = req_i.addr[WordOffsetBits +: SramIdxBits];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int i = 0; i < StrbWidth; i++) begin
          if (req_i.be[i]) begin
            mem[word_idx][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule
